//--- project.f
verilog/srl_fifo_pkg.sv
verilog/shift_register.sv
verilog/srl_fifo.sv
verilog/req_ack_receiver.sv
verilog/req_ack_sender.sv
verilog/srl_fifo_top.sv
testbench/tb_srl_fifo_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
rm -f sim.log
verilator --binary --assert -f project.f --top-module tb_srl_fifo_top &&
./obj_dir/Vtb_srl_fifo_top > sim.log 2>&1 ||
echo "build or simulation returned an error, TESTBENCH FAILED" >> sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/tb_srl_fifo_top.sv
`default_nettype none

module tb_srl_fifo_top;

    import srl_fifo_pkg::*;

    localparam int num_words   = 400;
    localparam int stall_words = fifo_depth + 1;
    localparam int stall_wait  = 50;
    localparam int cycle_limit = num_words * 20 + 2000;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   in_req;
    data_t  in_data;
    logic   in_ack;
    logic   out_req;
    data_t  out_data;
    logic   out_ack;
    count_t level;

    // Reference model, oldest word at index 0
    data_t       model [$];
    logic [31:0] rng_state = 32'h38c7;
    int          cycle_count = 0;

    srl_fifo_top srl_fifo_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .level    (level)
    );

    always #2 clk = ~clk;

    // ------------------------------
    // Failure reporting and checks
    // ------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_level(input count_t got, input count_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout: handshakes did not finish in %0d cycles",
                                cycle_limit));
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // Full four-phase cycle on the input side, word counted once acked
    task automatic send_word(input data_t value);
        in_data = value;
        in_req  = 1'b1;
        do begin
            @(negedge clk);
        end while (!in_ack);
        model.push_back(value);
        in_req = 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    // Output side, holds off ack for gap cycles
    task automatic receive_word(input logic [31:0] gap);
        do begin
            @(negedge clk);
        end while (!out_req);
        if (model.size() == 0) begin
            abort_run("out_req rose while the model holds no word");
        end else begin
            check_data(out_data, model[0], "out_data at out_req rise");
            repeat (gap) begin
                @(negedge clk);
                check_flag(out_req, 1'b1, "out_req before out_ack");
                check_data(out_data, model[0], "out_data while out_req high");
            end
            out_ack = 1'b1;
            @(negedge clk);
            check_flag(out_req, 1'b0, "out_req after out_ack");
            void'(model.pop_front());
            out_ack = 1'b0;
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic [31:0] rnd;
        arst_n  = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag(in_ack, 1'b0, "in_ack after reset");
        check_flag(out_req, 1'b0, "out_req after reset");
        check_level(level, '0, "level after reset");

        // Random traffic with gaps on both sides
        fork
            begin : input_side
                logic [31:0] r;
                for (int i = 0; i < num_words; i++) begin
                    next_random(r);
                    repeat (r & 32'h7) @(negedge clk);
                    next_random(r);
                    send_word(r[15:8]);
                end
            end
            begin : output_side
                logic [31:0] r;
                for (int i = 0; i < num_words; i++) begin
                    next_random(r);
                    receive_word(r & 32'h7);
                end
            end
        join
        @(negedge clk);
        check_level(level, '0, "level after random traffic");

        // Empty FIFO, idle output: out_req one clock behind in_ack
        next_random(rnd);
        fork
            send_word(rnd[7:0]);
            begin
                do begin
                    @(negedge clk);
                end while (!in_ack);
                check_flag(out_req, 1'b0, "out_req at in_ack rise");
                @(negedge clk);
                check_flag(out_req, 1'b1, "out_req one clock after in_ack");
            end
        join
        receive_word(32'd0);
        @(negedge clk);

        // Output stalled, sender holds one word and the FIFO fills
        for (int i = 0; i < stall_words; i++) begin
            next_random(rnd);
            send_word(rnd[7:0]);
        end
        @(negedge clk);
        check_level(level, count_t'(fifo_depth), "level with output stalled");
        next_random(rnd);
        in_data = rnd[7:0];
        in_req  = 1'b1;
        repeat (stall_wait) begin
            @(negedge clk);
            check_flag(in_ack, 1'b0, "in_ack while FIFO full");
            check_level(level, count_t'(fifo_depth), "level while stalled");
            check_flag(out_req, 1'b1, "out_req while stalled");
            check_data(out_data, model[0], "out_data while stalled");
        end
        in_req = 1'b0;

        // Drain in order
        for (int i = 0; i < stall_words; i++) begin
            next_random(rnd);
            receive_word(rnd & 32'h7);
        end
        @(negedge clk);
        check_level(level, '0, "level after drain");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/srl_fifo_top.sv
`default_nettype none

module srl_fifo_top (
    input  var logic                 clk,
    input  var logic                 arst_n,
    input  var logic                 in_req,
    input  var srl_fifo_pkg::data_t  in_data,
    output var logic                 in_ack,
    output var logic                 out_req,
    output var srl_fifo_pkg::data_t  out_data,
    input  var logic                 out_ack,
    output var srl_fifo_pkg::count_t level
);

    import srl_fifo_pkg::*;

    // ------------------------------
    // Internal links
    // ------------------------------

    logic  push;
    data_t push_data;
    logic  full;
    logic  pop;
    logic  empty;
    data_t head_data;

    req_ack_receiver req_ack_receiver_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    srl_fifo srl_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .full      (full),
        .empty     (empty),
        .level     (level)
    );

    req_ack_sender req_ack_sender_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (empty),
        .head_data (head_data),
        .pop       (pop),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

endmodule

`default_nettype wire

//--- verilog/req_ack_sender.sv
`default_nettype none

module req_ack_sender (
    input  var logic                clk,
    input  var logic                arst_n,
    input  var logic                empty,
    input  var srl_fifo_pkg::data_t head_data,
    output var logic                pop,
    output var logic                out_req,
    output var srl_fifo_pkg::data_t out_data,
    input  var logic                out_ack
);

    import srl_fifo_pkg::*;

    tx_state_t state;

    // ------------------------------
    // Handshake FSM
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (!empty) begin
                        state <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (out_ack) begin
                        state <= TX_RELEASE;
                    end
                end
                // No new pop until ack has gone low
                TX_RELEASE: begin
                    if (!out_ack) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign pop     = (state == TX_IDLE) && !empty;
    assign out_req = (state == TX_REQ);

    // Output word, loaded only when popping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_data <= '0;
        end else if (pop) begin
            out_data <= head_data;
        end
    end

    // Data held for the whole request phase
    a_data_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_req |=> (!out_req || $stable(out_data))
    ) else $error("out_data changed while out_req high");

endmodule

`default_nettype wire

//--- verilog/req_ack_receiver.sv
`default_nettype none

module req_ack_receiver (
    input  var logic                clk,
    input  var logic                arst_n,
    input  var logic                in_req,
    input  var srl_fifo_pkg::data_t in_data,
    output var logic                in_ack,
    input  var logic                full,
    output var logic                push,
    output var srl_fifo_pkg::data_t push_data
);

    import srl_fifo_pkg::*;

    rx_state_t state;

    // ------------------------------
    // Handshake FSM
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (in_req && !full) begin
                        state <= RX_ACK;
                    end
                end
                // Wait for the sender side to drop req
                RX_ACK: begin
                    if (!in_req) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Word is stored on the same edge that raises ack
    assign push      = (state == RX_IDLE) && in_req && !full;
    assign push_data = in_data;
    assign in_ack    = (state == RX_ACK);

    // One push per four-phase cycle
    a_single_push : assert property (
        @(posedge clk) disable iff (!arst_n)
        push |=> !push
    ) else $error("push held for two cycles");

endmodule

`default_nettype wire

//--- verilog/srl_fifo.sv
`default_nettype none

module srl_fifo (
    input  var logic                 clk,
    input  var logic                 arst_n,
    input  var logic                 push,
    input  var srl_fifo_pkg::data_t  push_data,
    input  var logic                 pop,
    output var srl_fifo_pkg::data_t  head_data,
    output var logic                 full,
    output var logic                 empty,
    output var srl_fifo_pkg::count_t level
);

    import srl_fifo_pkg::*;

    count_t count;
    addr_t  rd_addr;

    // ------------------------------
    // Occupancy
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                // Push and pop together leave the count alone
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == count_t'(fifo_depth));
    assign empty = (count == '0);
    assign level = count;

    // ------------------------------
    // Storage
    // ------------------------------

    // Oldest word sits at the deepest valid tap.
    // When empty the address wraps, head_data is then don't-care
    assign rd_addr = addr_t'(count - count_t'(1));

    shift_register shift_register_i (
        .clk      (clk),
        .cke      (push),
        .addr     (rd_addr),
        .in_data  (push_data),
        .out_data (head_data)
    );

    // ------------------------------
    // Checks
    // ------------------------------

    // Receiver must respect full
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(push && full)
    ) else $error("push while FIFO full");

    // Sender must respect empty
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(pop && empty)
    ) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

//--- verilog/shift_register.sv
`default_nettype none

module shift_register (
    input  var logic                clk,
    input  var logic                cke,
    input  var srl_fifo_pkg::addr_t addr,
    input  var srl_fifo_pkg::data_t in_data,
    output var srl_fifo_pkg::data_t out_data
);

    import srl_fifo_pkg::*;

    // ------------------------------
    // Storage
    // ------------------------------

    // Tap 0 holds the newest word
    data_t taps [fifo_depth];

    always_ff @(posedge clk) begin
        if (cke) begin
            taps[0] <= in_data;
            for (int i = 1; i < fifo_depth; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // ------------------------------
    // Tap select
    // ------------------------------

    // Addressed read, no register in the path
    always_comb begin
        out_data = taps[addr];
    end

endmodule

`default_nettype wire

//--- verilog/srl_fifo_pkg.sv
`default_nettype none

package srl_fifo_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    // Payload word width
    localparam int data_width  = 8;

    // Number of shift register taps
    localparam int fifo_depth  = 16;
    localparam int addr_width  = $clog2(fifo_depth);

    // One extra bit so the count reaches fifo_depth
    localparam int count_width = addr_width + 1;

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [data_width-1:0]  data_t;
    typedef logic [addr_width-1:0]  addr_t;
    typedef logic [count_width-1:0] count_t;

    // Input handshake FSM
    typedef enum logic [0:0] {
        RX_IDLE,
        RX_ACK
    } rx_state_t;

    // Output handshake FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_RELEASE
    } tx_state_t;

endpackage

`default_nettype wire
